/* flist.f */
+incdir+common
common/mux_pkg.sv
logic/mux_spill_reg.sv
aw_arb/mux_aw_arbiter.sv
logic/mux_w_router.sv
logic/mcast_mux_top.sv
verif/tb_mcast_mux.sv

/* Bender.yml */
package:
  name: mcast_mux

sources:
  - include_dirs:
      - common
    files:
      - common/mux_pkg.sv
      - logic/mux_spill_reg.sv
      - aw_arb/mux_aw_arbiter.sv
      - logic/mux_w_router.sv
      - logic/mcast_mux_top.sv
      - target: test
        files:
          - verif/tb_mcast_mux.sv

/* verif/tb_mcast_mux.sv */
// Testbench for the multicast-aware write-path multiplexer
// Per-port AW and W drivers, master ready and B drivers, scoreboard queues,
// checking assertions, watchdog and closing summary

`timescale 1ns/1ns
`include "mux_config.svh"

module tb_mcast_mux;
  import mux_pkg::*;

  localparam int NP             = `MUX_NUM_PORTS;
  localparam int NUM_TESTS      = 40;
  localparam int MAX_LEN        = 8;
  localparam int SEED           = 45;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_LEN * 40;

  // One AW request as the slave port sends it, with its W tag fields
  typedef struct packed {
    logic      mc;
    port_idx_t port;
    slv_id_t   id;
    addr_t     addr;
    len_t      len;
    logic [5:0] seq;
  } req_t;

  logic clk, rst_n;
  slv_aw_t [NP-1:0] slv_aw;
  logic    [NP-1:0] slv_aw_valid, slv_aw_ready, slv_mcast;
  w_chan_t [NP-1:0] slv_w;
  logic    [NP-1:0] slv_w_valid, slv_w_ready;
  slv_b_t  [NP-1:0] slv_b;
  logic    [NP-1:0] slv_b_valid, slv_b_ready;
  logic             mcast_commit;
  mst_aw_t          mst_aw;
  logic             mst_aw_valid, mst_aw_ready;
  w_chan_t          mst_w;
  logic             mst_w_valid, mst_w_ready;
  mst_b_t           mst_b;
  logic             mst_b_valid, mst_b_ready;

  // Scoreboard state
  req_t       req_q [NP][$];
  req_t       exp_q [NP][$];
  req_t       w_q   [NP][$];
  req_t       order_q [$];
  mst_b_t     b_exp_q [$];
  logic [5:0] seq_cnt [NP];
  int         value_errs, other_errs, commits, w_beat;
  logic       mc_pending, w_hold, force_aw_rdy, b_done;
  logic       aw_stall_q, w_stall_q;
  mst_aw_t    aw_prev;
  w_chan_t    w_prev;

  mcast_mux_top DUT (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .slv_aw_i       ( slv_aw       ),
    .slv_aw_valid_i ( slv_aw_valid ),
    .slv_aw_ready_o ( slv_aw_ready ),
    .slv_mcast_i    ( slv_mcast    ),
    .mcast_commit_i ( mcast_commit ),
    .slv_w_i        ( slv_w        ),
    .slv_w_valid_i  ( slv_w_valid  ),
    .slv_w_ready_o  ( slv_w_ready  ),
    .slv_b_o        ( slv_b        ),
    .slv_b_valid_o  ( slv_b_valid  ),
    .slv_b_ready_i  ( slv_b_ready  ),
    .mst_aw_o       ( mst_aw       ),
    .mst_aw_valid_o ( mst_aw_valid ),
    .mst_aw_ready_i ( mst_aw_ready ),
    .mst_w_o        ( mst_w        ),
    .mst_w_valid_o  ( mst_w_valid  ),
    .mst_w_ready_i  ( mst_w_ready  ),
    .mst_b_i        ( mst_b        ),
    .mst_b_valid_i  ( mst_b_valid  ),
    .mst_b_ready_o  ( mst_b_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Error reporting
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    value_errs++;
    $display("MISMATCH at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_failure(input string msg);
    other_errs++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("Summary: %0d value mismatches, %0d other failures", value_errs, other_errs);
  endtask

  // Valid must hold through a master stall
  a_aw_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mst_aw_valid && !mst_aw_ready |=> mst_aw_valid)
    else report_mismatch("mst_aw_valid_o", 32'd1, 32'd0);

  a_w_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mst_w_valid && !mst_w_ready |=> mst_w_valid)
    else report_mismatch("mst_w_valid_o", 32'd1, 32'd0);

  // Slave W ready only passes the master ready to a single port
  a_w_ready_steer: assert property (@(posedge clk) disable iff (!rst_n)
    slv_w_ready != '0 |-> mst_w_ready && $onehot(slv_w_ready))
    else report_failure("W ready raised on several slave ports or without master ready");

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic enqueue_aw(input int p, input logic mc);
    req_t r;
    r.mc    = mc;
    r.port  = port_idx_t'(p);
    r.id    = slv_id_t'($urandom);
    r.addr  = addr_t'($urandom);
    r.len   = len_t'($urandom_range(MAX_LEN - 1, 0));
    r.seq   = seq_cnt[p];
    seq_cnt[p] = seq_cnt[p] + 6'd1;
    req_q[p].push_back(r);
    exp_q[p].push_back(r);
    w_q[p].push_back(r);
  endtask

  task automatic pulse_commit();
    @(posedge clk);
    mcast_commit <= 1'b1;
    @(posedge clk);
    mcast_commit <= 1'b0;
  endtask

  task automatic wait_idle();
    int busy;
    do begin
      @(posedge clk);
      busy = order_q.size();
      for (int p = 0; p < NP; p++) begin
        busy += req_q[p].size() + exp_q[p].size() + w_q[p].size();
      end
    end while (busy != 0);
  endtask

  // Multicast on port m, unicast on the others once it is pending
  task automatic mcast_round(input int m);
    enqueue_aw(m, 1'b1);
    while (!mc_pending) @(posedge clk);
    for (int p = 0; p < NP; p++) begin
      if (p != m) enqueue_aw(p, 1'b0);
    end
    repeat (8) @(posedge clk);
    pulse_commit();
    wait_idle();
  endtask

  // ----------------------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < NP; g++) begin : gen_port_drv
    initial begin
      req_t r;
      forever begin
        @(posedge clk);
        if (rst_n && req_q[g].size() > 0) begin
          r = req_q[g].pop_front();
          slv_aw[g]       <= '{id: r.id, addr: r.addr, len: r.len};
          slv_aw_valid[g] <= 1'b1;
          slv_mcast[g]    <= r.mc;
          do @(posedge clk); while (!slv_aw_ready[g]);
          slv_aw_valid[g] <= 1'b0;
          slv_mcast[g]    <= 1'b0;
        end
      end
    end

    // Beat data carries port, burst sequence and beat number
    initial begin
      req_t r;
      forever begin
        @(posedge clk);
        if (!w_hold && w_q[g].size() > 0) begin
          r = w_q[g].pop_front();
          for (int b = 0; b <= int'(r.len); b++) begin
            slv_w[g] <= '{data: {port_idx_t'(g), r.seq, 8'(b)}, last: (b == int'(r.len))};
            slv_w_valid[g] <= 1'b1;
            do @(posedge clk); while (!slv_w_ready[g]);
          end
          slv_w_valid[g] <= 1'b0;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      mst_aw_ready <= force_aw_rdy || ($urandom_range(3, 0) != 0);
      mst_w_ready  <= ($urandom_range(3, 0) != 0);
      slv_b_ready  <= NP'($urandom);
    end
  end

  initial begin
    do @(posedge clk); while (!rst_n);
    for (int n = 0; n < NUM_TESTS; n++) begin
      @(posedge clk);
      mst_b       <= '{id: mst_id_t'($urandom), resp: resp_t'($urandom)};
      mst_b_valid <= 1'b1;
      do @(posedge clk); while (!mst_b_ready);
      mst_b_valid <= 1'b0;
    end
    b_done = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Monitor and scoreboard
  // ----------------------------------------------------------------------
  task automatic check_aw_issue(input int outstanding);
    port_idx_t p;
    req_t      r;
    p = mst_aw.id[`MUX_MST_ID_W-1 -: `MUX_PORT_IDX_W];
    if (outstanding >= `MUX_W_DEPTH) report_failure("AW issued while the W order FIFO was full");
    if (exp_q[p].size() == 0) begin
      report_failure("AW at the master from a port with no request pending");
      return;
    end
    r = exp_q[p].pop_front();
    assert (mst_aw.id[`MUX_SLV_ID_W-1:0] == r.id)
      else report_mismatch("mst_aw_o.id", {p, r.id}, mst_aw.id);
    assert (mst_aw.addr == r.addr) else report_mismatch("mst_aw_o.addr", r.addr, mst_aw.addr);
    assert (mst_aw.len == r.len) else report_mismatch("mst_aw_o.len", r.len, mst_aw.len);
    if (r.mc) begin
      if (commits == 0) report_failure("multicast AW reached the master before a commit");
      mc_pending = 1'b0;
    end else if (mc_pending) begin
      report_failure("unicast AW issued while a multicast request was pending");
    end
    order_q.push_back(r);
  endtask

  always @(posedge clk) begin
    int     outstanding;
    int     q;
    req_t   h;
    mst_b_t e;
    if (!rst_n) begin
      aw_stall_q = 1'b0;
      w_stall_q  = 1'b0;
      w_beat     = 0;
    end else begin
      outstanding = order_q.size();
      if (w_stall_q) assert (mst_w == w_prev) else report_mismatch("mst_w_o", w_prev, mst_w);
      if (mst_w_valid && mst_w_ready) begin
        if (order_q.size() == 0) begin
          report_failure("W beat at the master with no AW issued");
        end else begin
          h = order_q[0];
          assert (mst_w.data == {h.port, h.seq, 8'(w_beat)})
            else report_mismatch("mst_w_o.data", {h.port, h.seq, 8'(w_beat)}, mst_w.data);
          assert (mst_w.last == (w_beat == int'(h.len)))
            else report_mismatch("mst_w_o.last", (w_beat == int'(h.len)), mst_w.last);
          // Follow the DUT's last so one error does not shift every later beat
          if (mst_w.last) begin
            void'(order_q.pop_front());
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end
      if (aw_stall_q) assert (mst_aw == aw_prev) else report_mismatch("mst_aw_o", aw_prev, mst_aw);
      if (mst_aw_valid && !aw_stall_q) check_aw_issue(outstanding);
      if (mc_pending && mcast_commit) commits++;
      for (int i = 0; i < NP; i++) begin
        if (slv_aw_valid[i] && slv_aw_ready[i] && slv_mcast[i]) begin
          mc_pending = 1'b1;
          commits    = 0;
        end
      end
      // B routing, master responses leave in arrival order
      if (slv_b_valid != '0) begin
        assert ($onehot(slv_b_valid)) else report_failure("B valid raised on several slave ports");
        q = 0;
        for (int i = 0; i < NP; i++) if (slv_b_valid[i]) q = i;
        if (b_exp_q.size() == 0) begin
          report_failure("B response on a slave port with none sent by the master");
        end else begin
          e = b_exp_q[0];
          assert (q == int'(e.id[`MUX_MST_ID_W-1 -: `MUX_PORT_IDX_W]))
            else report_mismatch("slv_b_valid_o", 32'd1 << e.id[`MUX_MST_ID_W-1 -: `MUX_PORT_IDX_W],
                                 slv_b_valid);
          assert (slv_b[q].id == e.id[`MUX_SLV_ID_W-1:0])
            else report_mismatch("slv_b_o.id", e.id[`MUX_SLV_ID_W-1:0], slv_b[q].id);
          assert (slv_b[q].resp == e.resp) else report_mismatch("slv_b_o.resp", e.resp, slv_b[q].resp);
          if (slv_b_ready[q]) void'(b_exp_q.pop_front());
        end
      end
      if (mst_b_valid && mst_b_ready) b_exp_q.push_back(mst_b);
      aw_stall_q = mst_aw_valid && !mst_aw_ready;
      w_stall_q  = mst_w_valid && !mst_w_ready;
      aw_prev    = mst_aw;
      w_prev     = mst_w;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_failure("run did not finish within the cycle limit");
    print_summary();
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_n        = 1'b0;
    slv_aw       = '0;
    slv_aw_valid = '0;
    slv_mcast    = '0;
    slv_w        = '0;
    slv_w_valid  = '0;
    slv_b_ready  = '0;
    mcast_commit = 1'b0;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    value_errs   = 0;
    other_errs   = 0;
    commits      = 0;
    mc_pending   = 1'b0;
    w_hold       = 1'b0;
    force_aw_rdy = 1'b0;
    b_done       = 1'b0;
    for (int p = 0; p < NP; p++) seq_cnt[p] = '0;
    repeat (5) @(posedge clk);
    // Ingress stages accept nothing while reset is held
    assert (slv_aw_ready == '0) else report_mismatch("slv_aw_ready_o", 32'd0, slv_aw_ready);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!mst_aw_valid) else report_mismatch("mst_aw_valid_o", 32'd0, mst_aw_valid);
    assert (!mst_w_valid) else report_mismatch("mst_w_valid_o", 32'd0, mst_w_valid);
    assert (slv_b_valid == '0) else report_mismatch("slv_b_valid_o", 32'd0, slv_b_valid);

    // Random unicast traffic on all ports
    for (int n = 0; n < NUM_TESTS; n++) enqueue_aw($urandom_range(NP - 1, 0), 1'b0);
    wait_idle();

    // A commit with nothing held must be ignored
    pulse_commit();
    repeat (4) @(posedge clk);
    mcast_round($urandom_range(NP - 1, 0));
    mcast_round($urandom_range(NP - 1, 0));

    // Withhold W so the order FIFO fills up
    force_aw_rdy = 1'b1;
    w_hold       = 1'b1;
    for (int n = 0; n < `MUX_W_DEPTH + 2; n++) enqueue_aw(n % NP, 1'b0);
    repeat (30) @(posedge clk);
    assert (order_q.size() == `MUX_W_DEPTH)
      else report_mismatch("issued AW count", `MUX_W_DEPTH, order_q.size());
    w_hold       = 1'b0;
    force_aw_rdy = 1'b0;
    wait_idle();

    while (!b_done || b_exp_q.size() != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    print_summary();
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* logic/mcast_mux_top.sv */
// Top level of the multicast-aware write-path multiplexer
// ID prepend, per-port AW ingress with multicast flag tracking,
// AW arbiter, W router and ID-based B routing

`timescale 1ns/1ns
`include "mux_config.svh"

module mcast_mux_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  mux_pkg::slv_aw_t [`MUX_NUM_PORTS-1:0] slv_aw_i,
  input  logic             [`MUX_NUM_PORTS-1:0] slv_aw_valid_i,
  output logic             [`MUX_NUM_PORTS-1:0] slv_aw_ready_o,
  input  logic             [`MUX_NUM_PORTS-1:0] slv_mcast_i,
  input  logic                                  mcast_commit_i,
  input  mux_pkg::w_chan_t [`MUX_NUM_PORTS-1:0] slv_w_i,
  input  logic             [`MUX_NUM_PORTS-1:0] slv_w_valid_i,
  output logic             [`MUX_NUM_PORTS-1:0] slv_w_ready_o,
  output mux_pkg::slv_b_t  [`MUX_NUM_PORTS-1:0] slv_b_o,
  output logic             [`MUX_NUM_PORTS-1:0] slv_b_valid_o,
  input  logic             [`MUX_NUM_PORTS-1:0] slv_b_ready_i,
  output mux_pkg::mst_aw_t                      mst_aw_o,
  output logic                                  mst_aw_valid_o,
  input  logic                                  mst_aw_ready_i,
  output mux_pkg::w_chan_t                      mst_w_o,
  output logic                                  mst_w_valid_o,
  input  logic                                  mst_w_ready_i,
  input  mux_pkg::mst_b_t                       mst_b_i,
  input  logic                                  mst_b_valid_i,
  output logic                                  mst_b_ready_o
);
  import mux_pkg::*;

  localparam int NP = `MUX_NUM_PORTS;

  mst_aw_t [NP-1:0] ing_aw_in, ing_aw;
  logic    [NP-1:0] ing_valid, ing_ready, ing_mcast;
  logic             push, w_full;
  port_idx_t        push_idx;
  mst_b_t           b_q;
  logic             b_valid;
  port_idx_t        b_port;

  // ------------------------------------------------------------------
  // AW ingress, one spill stage per slave port
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NP; i++) begin : gen_ingress
    logic [1:0] flag_q, flag_d;
    logic [1:0] cnt_q, cnt_d;
    logic       in_hs, out_hs;

    // Port index goes above the slave ID
    assign ing_aw_in[i] = '{id:   {port_idx_t'(i), slv_aw_i[i].id},
                            addr: slv_aw_i[i].addr,
                            len:  slv_aw_i[i].len};

    mux_spill_reg #(
      .T ( mst_aw_t )
    ) i_aw_spill (
      .clk_i   ( clk_i             ),
      .rst_n_i ( rst_n_i           ),
      .valid_i ( slv_aw_valid_i[i] ),
      .ready_o ( slv_aw_ready_o[i] ),
      .data_i  ( ing_aw_in[i]      ),
      .valid_o ( ing_valid[i]      ),
      .ready_i ( ing_ready[i]      ),
      .data_o  ( ing_aw[i]         )
    );

    // Multicast flag follows each entry through the two-deep stage
    assign in_hs  = slv_aw_valid_i[i] && slv_aw_ready_o[i];
    assign out_hs = ing_valid[i] && ing_ready[i];

    always_comb begin
      flag_d = flag_q;
      cnt_d  = cnt_q;
      if (out_hs) begin
        flag_d = {1'b0, flag_q[1]};
        cnt_d  = cnt_q - 2'd1;
      end
      if (in_hs) begin
        flag_d[cnt_d[0]] = slv_mcast_i[i];
        cnt_d            = cnt_d + 2'd1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) cnt_q <= '0;
      else cnt_q <= cnt_d;
    end

    always_ff @(posedge clk_i) begin
      flag_q <= flag_d;
    end

    assign ing_mcast[i] = flag_q[0];
  end

  mux_aw_arbiter i_aw_arbiter (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .in_aw_i        ( ing_aw         ),
    .in_valid_i     ( ing_valid      ),
    .in_ready_o     ( ing_ready      ),
    .mcast_i        ( ing_mcast      ),
    .mcast_commit_i ( mcast_commit_i ),
    .aw_o           ( mst_aw_o       ),
    .aw_valid_o     ( mst_aw_valid_o ),
    .aw_ready_i     ( mst_aw_ready_i ),
    .fifo_full_i    ( w_full         ),
    .push_o         ( push           ),
    .push_idx_o     ( push_idx       )
  );

  mux_w_router i_w_router (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .push_i        ( push          ),
    .push_idx_i    ( push_idx      ),
    .full_o        ( w_full        ),
    .slv_w_i       ( slv_w_i       ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_o       ( mst_w_o       ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  // ------------------------------------------------------------------
  // B response, routed by the upper ID bits
  // ------------------------------------------------------------------
  mux_spill_reg #(
    .T ( mst_b_t )
  ) i_b_spill (
    .clk_i   ( clk_i                 ),
    .rst_n_i ( rst_n_i               ),
    .valid_i ( mst_b_valid_i         ),
    .ready_o ( mst_b_ready_o         ),
    .data_i  ( mst_b_i               ),
    .valid_o ( b_valid               ),
    .ready_i ( slv_b_ready_i[b_port] ),
    .data_o  ( b_q                   )
  );

  assign b_port        = b_q.id[`MUX_MST_ID_W-1 -: `MUX_PORT_IDX_W];
  assign slv_b_valid_o = b_valid ? ({{(NP-1){1'b0}}, 1'b1} << b_port) : '0;

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      slv_b_o[p].id   = b_q.id[`MUX_SLV_ID_W-1:0];
      slv_b_o[p].resp = b_q.resp;
    end
  end

endmodule

/* logic/mux_w_router.sv */
// W beat steering for the write-path multiplexer
// FIFO of port indices in AW issue order, head port drives the master W,
// pop on the last beat

`timescale 1ns/1ns
`include "mux_config.svh"

module mux_w_router (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  push_i,
  input  mux_pkg::port_idx_t                    push_idx_i,
  output logic                                  full_o,
  input  mux_pkg::w_chan_t [`MUX_NUM_PORTS-1:0] slv_w_i,
  input  logic             [`MUX_NUM_PORTS-1:0] slv_w_valid_i,
  output logic             [`MUX_NUM_PORTS-1:0] slv_w_ready_o,
  output mux_pkg::w_chan_t                      mst_w_o,
  output logic                                  mst_w_valid_o,
  input  logic                                  mst_w_ready_i
);
  import mux_pkg::*;

  localparam int DEPTH = `MUX_W_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  port_idx_t             fifo_q [DEPTH];
  logic      [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic      [CNT_W-1:0] count_q;
  logic                  empty, pop;
  port_idx_t             head;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CNT_W'(DEPTH));
  assign head   = fifo_q[rd_ptr_q];

  // ------------------------------------------------------------------
  // Handshake steering, no added cycles
  // ------------------------------------------------------------------
  assign mst_w_o = slv_w_i[head];

  always_comb begin
    slv_w_ready_o = '0;
    mst_w_valid_o = 1'b0;
    if (!empty) begin
      mst_w_valid_o       = slv_w_valid_i[head];
      slv_w_ready_o[head] = mst_w_ready_i;
    end
  end

  assign pop = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

  // ------------------------------------------------------------------
  // Port index FIFO
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) fifo_q[wr_ptr_q] <= push_idx_i;
  end

endmodule

/* aw_arb/mux_aw_arbiter.sv */
// AW arbitration for the write-path multiplexer
// Round-robin unicast, priority multicast held until commit,
// output lock for master stalls, W-order FIFO push

`timescale 1ns/1ns
`include "mux_config.svh"

module mux_aw_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  mux_pkg::mst_aw_t [`MUX_NUM_PORTS-1:0] in_aw_i,
  input  logic             [`MUX_NUM_PORTS-1:0] in_valid_i,
  output logic             [`MUX_NUM_PORTS-1:0] in_ready_o,
  input  logic             [`MUX_NUM_PORTS-1:0] mcast_i,
  input  logic                                  mcast_commit_i,
  output mux_pkg::mst_aw_t                      aw_o,
  output logic                                  aw_valid_o,
  input  logic                                  aw_ready_i,
  input  logic                                  fifo_full_i,
  output logic                                  push_o,
  output mux_pkg::port_idx_t                    push_idx_o
);
  import mux_pkg::*;

  localparam int NP = `MUX_NUM_PORTS;

  logic [NP-1:0] uc_req, mc_req;
  port_idx_t     rr_ptr_q, uc_sel, mc_sel;
  logic          uc_found, mc_found;
  logic          mc_held_q, mc_commit_q, mc_accept;
  mst_aw_t       mc_aw_q;
  logic          lock_q;
  mst_aw_t       lock_aw_q, cand_aw;
  logic          cand_valid, issue, uc_issue, mc_issue;

  assign uc_req = in_valid_i & ~mcast_i;
  assign mc_req = in_valid_i & mcast_i;

  // ------------------------------------------------------------------
  // Request selection
  // ------------------------------------------------------------------
  // Unicast: first request at or after the round-robin pointer
  always_comb begin
    int unsigned idx;
    uc_found = 1'b0;
    uc_sel   = rr_ptr_q;
    for (int k = 0; k < NP; k++) begin
      idx = (int'(rr_ptr_q) + k) % NP;
      if (!uc_found && uc_req[idx]) begin
        uc_found = 1'b1;
        uc_sel   = port_idx_t'(idx);
      end
    end
  end

  // Multicast: lowest port wins
  always_comb begin
    mc_found = 1'b0;
    mc_sel   = '0;
    for (int k = NP - 1; k >= 0; k--) begin
      if (mc_req[k]) begin
        mc_found = 1'b1;
        mc_sel   = port_idx_t'(k);
      end
    end
  end

  assign mc_accept = mc_found && !mc_held_q;

  // ------------------------------------------------------------------
  // Issue toward the master
  // ------------------------------------------------------------------
  // Any pending or held multicast blocks unicast grants
  assign cand_aw    = mc_commit_q ? mc_aw_q : in_aw_i[uc_sel];
  assign cand_valid = !fifo_full_i &&
                      (mc_commit_q || (uc_found && !mc_found && !mc_held_q));
  assign issue      = !lock_q && cand_valid;
  assign uc_issue   = issue && !mc_commit_q;
  assign mc_issue   = issue && mc_commit_q;

  assign aw_valid_o = lock_q || issue;
  assign aw_o       = lock_q ? lock_aw_q : cand_aw;
  assign push_o     = issue;
  assign push_idx_o = cand_aw.id[`MUX_MST_ID_W-1 -: `MUX_PORT_IDX_W];

  always_comb begin
    in_ready_o = '0;
    if (uc_issue) in_ready_o[uc_sel] = 1'b1;
    if (mc_accept) in_ready_o[mc_sel] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q    <= '0;
      mc_held_q   <= 1'b0;
      mc_commit_q <= 1'b0;
      lock_q      <= 1'b0;
    end else begin
      if (uc_issue) rr_ptr_q <= port_idx_t'((int'(uc_sel) + 1) % NP);
      if (mc_accept) mc_held_q <= 1'b1;
      else if (mc_issue) mc_held_q <= 1'b0;
      // Commit only counts while a multicast AW is held
      if (mc_issue) mc_commit_q <= 1'b0;
      else if (mc_held_q && mcast_commit_i) mc_commit_q <= 1'b1;
      // Stalled AW stays on the bus without a second push
      if (issue && !aw_ready_i) lock_q <= 1'b1;
      else if (lock_q && aw_ready_i) lock_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mc_accept) mc_aw_q <= in_aw_i[mc_sel];
    if (issue) lock_aw_q <= cand_aw;
  end

endmodule

/* logic/mux_spill_reg.sv */
// Two-entry valid/ready spill register
// Cuts the ready path, keeps one transfer per cycle, payload type T

`timescale 1ns/1ns

module mux_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic live_q;
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  // Entry A takes every input, entry B only catches A on an output stall
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      live_q   <= 1'b0;
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B holds the older entry whenever it is full
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = live_q && (!a_full_q || !b_full_q);

endmodule

/* common/mux_pkg.sv */
// Channel types shared by the multiplexer blocks
// Port index, slave and master AW structs, W struct, slave and master B structs

`include "mux_config.svh"

package mux_pkg;

  typedef logic [`MUX_PORT_IDX_W-1:0] port_idx_t;
  typedef logic [`MUX_SLV_ID_W-1:0]   slv_id_t;
  typedef logic [`MUX_MST_ID_W-1:0]   mst_id_t;
  typedef logic [`MUX_ADDR_W-1:0]     addr_t;
  typedef logic [`MUX_DATA_W-1:0]     data_t;
  typedef logic [7:0]                 len_t;
  typedef logic [1:0]                 resp_t;

  // AW as seen on a slave port
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_aw_t;

  // AW on the master port, ID extended by the port index
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_aw_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } mst_b_t;

endpackage

/* common/mux_config.svh */
// Build-time configuration of the write-path multiplexer
// Port count, ID, address and data widths, W-order FIFO depth

`ifndef MUX_CONFIG_SVH
`define MUX_CONFIG_SVH

// Slave ports and the index that selects one of them
`define MUX_NUM_PORTS  4
`define MUX_PORT_IDX_W 2

// Master ID carries the port index above the slave ID
`define MUX_SLV_ID_W   2
`define MUX_MST_ID_W   4

`define MUX_ADDR_W     16
`define MUX_DATA_W     16
`define MUX_W_DEPTH    4

`endif
